// ==== Bender.yml ====
package:
  name: metro_spu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spu_pkg.sv
      - hdl/spu_reg_file.sv
      - hdl/wave_ram_arbiter.sv
      - hdl/length_unit.sv
      - hdl/pulse_channel.sv
      - hdl/wave_channel.sv
      - hdl/spu_mixer.sv
      - hdl/metro_spu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/spu_tb.sv

// ==== hdl/length_unit.sv ====
`include "spu_consts.svh"

module length_unit (
  input  logic                  clock,
  input  logic                  tick_reset,
  input  spu_pkg::spu_regs_t    regs,
  input  spu_pkg::spu_trig_t    trig,
  output spu_pkg::spu_enables_t enables
);

  logic [`SPU_FRAME_BITS-1:0] frame_cnt;
  logic                       frame_wrap;
  logic [8:0]                 pulse_len;
  logic [8:0]                 wave_len;
  logic [8:0]                 pulse_next;
  logic [8:0]                 wave_next;

  // count down, holding at zero
  function automatic logic [8:0] len_step(input logic [8:0] len);
    len_step = (len != 9'd0) ? len - 9'd1 : 9'd0;
  endfunction

  // next count wraps to zero
  assign frame_wrap = &frame_cnt;
  assign pulse_next = len_step(pulse_len);
  assign wave_next  = len_step(wave_len);

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      frame_cnt <= '0;
      pulse_len <= '0;
      wave_len  <= '0;
      enables   <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;

      if (frame_wrap && regs.nr24[`SPU_LEN_EN_BIT]) begin
        pulse_len <= pulse_next;
        if (pulse_next == 9'd0) begin
          enables.pulse <= 1'b0;
        end
      end
      if (frame_wrap && regs.nr34[`SPU_LEN_EN_BIT]) begin
        wave_len <= wave_next;
        if (wave_next == 9'd0) begin
          enables.wave <= 1'b0;
        end
      end

      // trigger wins over a length step in the same cycle
      if (trig.pulse) begin
        pulse_len     <= 9'd64 - {3'd0, regs.nr21[5:0]};
        enables.pulse <= (regs.nr22 & `SPU_DAC_MASK) != 8'd0;
      end
      if (trig.wave) begin
        wave_len     <= 9'd256 - {1'b0, regs.nr31};
        enables.wave <= (regs.nr32 != 8'd0) && regs.nr30[`SPU_POWER_BIT];
      end
    end
  end

endmodule

// ==== hdl/metro_spu.sv ====
module metro_spu (
  input  logic               clock,
  input  logic               tick_reset,
  input  spu_pkg::spu_addr_t tick_addr,
  input  spu_pkg::spu_data_t tick_data,
  input  logic               tick_we,
  input  spu_pkg::spu_addr_t tock_ack_addr,
  output spu_pkg::spu_data_t ack_data,
  output logic               ack_valid,
  output spu_pkg::sample_t   out_l,
  output spu_pkg::sample_t   out_r
);
  import spu_pkg::*;

  spu_regs_t     regs;
  spu_trig_t     trig;
  spu_enables_t  enables;
  wave_bus_req_t wave_req;
  wave_byte_u    wave_rdata;
  wave_byte_u    fetch_data;
  logic          fetch_req;
  logic [3:0]    fetch_index;
  logic          fetch_grant;
  chan_sample_t  pulse_out;
  chan_sample_t  wave_out;

  spu_reg_file i_reg_file (
    .clock(clock), .tick_reset(tick_reset), .tick_we(tick_we),
    .tick_addr(tick_addr), .tock_ack_addr(tock_ack_addr), .tick_data(tick_data),
    .wave_rdata(wave_rdata), .enables(enables), .regs(regs), .trig(trig),
    .wave_req(wave_req), .ack_data(ack_data), .ack_valid(ack_valid)
  );

  wave_ram_arbiter i_wave_ram (
    .clock(clock), .tick_reset(tick_reset), .wave_req(wave_req),
    .wave_rdata(wave_rdata), .fetch_req(fetch_req), .fetch_index(fetch_index),
    .fetch_grant(fetch_grant), .fetch_data(fetch_data)
  );

  length_unit i_length (
    .clock(clock), .tick_reset(tick_reset), .regs(regs), .trig(trig),
    .enables(enables)
  );

  pulse_channel i_pulse (
    .clock(clock), .tick_reset(tick_reset), .regs(regs), .trig(trig),
    .enables(enables), .pulse_out(pulse_out)
  );

  wave_channel i_wave (
    .clock(clock), .tick_reset(tick_reset), .regs(regs), .trig(trig),
    .enables(enables), .fetch_req(fetch_req), .fetch_index(fetch_index),
    .fetch_grant(fetch_grant), .fetch_data(fetch_data), .wave_out(wave_out)
  );

  spu_mixer i_mixer (
    .pulse_out(pulse_out), .wave_out(wave_out), .regs(regs),
    .out_l(out_l), .out_r(out_r)
  );

endmodule

// ==== hdl/pulse_channel.sv ====
`include "spu_consts.svh"

module pulse_channel (
  input  logic                  clock,
  input  logic                  tick_reset,
  input  spu_pkg::spu_regs_t    regs,
  input  spu_pkg::spu_trig_t    trig,
  input  spu_pkg::spu_enables_t enables,
  output spu_pkg::chan_sample_t pulse_out
);

  logic [10:0] period_cnt;
  logic [10:0] reload;
  logic [2:0]  phase;
  logic [1:0]  duty_code;
  logic [3:0]  duty_w;

  assign reload    = 11'(`SPU_FREQ_MAX) ^ {regs.nr24[2:0], regs.nr23};
  assign duty_code = regs.nr21[7:6];
  // 12.5 / 25 / 50 / 75 percent
  assign duty_w    = (duty_code == 2'd0) ? 4'd1 : {1'b0, duty_code, 1'b0};

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      period_cnt <= '0;
      phase      <= '0;
      pulse_out  <= '0;
    end else begin
      // start volume from nr22, no envelope
      if (enables.pulse && ({1'b0, phase} < duty_w)) begin
        pulse_out <= {4'd0, regs.nr22[7:4]};
      end else begin
        pulse_out <= '0;
      end

      if (trig.pulse) begin
        period_cnt <= reload;
        phase      <= '0;
      end else if (period_cnt == 11'd0) begin
        period_cnt <= reload;
        phase      <= phase + 3'd1;
      end else begin
        period_cnt <= period_cnt - 11'd1;
      end
    end
  end

endmodule

// ==== hdl/spu_consts.svh ====
`ifndef SPU_CONSTS_SVH
`define SPU_CONSTS_SVH

// ---------------------------------------------------------------------------
// widths and limits
// ---------------------------------------------------------------------------
`define SPU_ADDR_W      16
`define SPU_DATA_W      8
`define SPU_SAMPLE_W    16
`define SPU_FREQ_MAX    2047
`define SPU_FRAME_BITS  14
`define SPU_WAVE_DEPTH  16

// ---------------------------------------------------------------------------
// register map
// ---------------------------------------------------------------------------
`define SPU_ADDR_REG_BASE  16'hFF10
`define SPU_ADDR_NR21      16'hFF16
`define SPU_ADDR_NR22      16'hFF17
`define SPU_ADDR_NR23      16'hFF18
`define SPU_ADDR_NR24      16'hFF19
`define SPU_ADDR_NR30      16'hFF1A
`define SPU_ADDR_NR31      16'hFF1B
`define SPU_ADDR_NR32      16'hFF1C
`define SPU_ADDR_NR33      16'hFF1D
`define SPU_ADDR_NR34      16'hFF1E
`define SPU_ADDR_NR50      16'hFF24
`define SPU_ADDR_NR51      16'hFF25
`define SPU_ADDR_NR52      16'hFF26
`define SPU_ADDR_WAVE_BASE 16'hFF30
`define SPU_ADDR_WAVE_TOP  16'hFF3F

// read-back masks, ORed into the stored value
`define SPU_RMASK_NR21  8'h3F
`define SPU_RMASK_NR22  8'h00
`define SPU_RMASK_NR23  8'hFF
`define SPU_RMASK_NR24  8'hBF
`define SPU_RMASK_NR30  8'h7F
`define SPU_RMASK_NR31  8'hFF
`define SPU_RMASK_NR32  8'h9F
`define SPU_RMASK_NR33  8'hFF
`define SPU_RMASK_NR34  8'hBF
`define SPU_RMASK_NR50  8'h00
`define SPU_RMASK_NR51  8'h00
`define SPU_RMASK_NR52  8'h70

// bits forced high on write
`define SPU_WMASK_NR24  8'h38
`define SPU_WMASK_NR30  8'h7F
`define SPU_WMASK_NR32  8'h9F
`define SPU_WMASK_NR34  8'h38
`define SPU_WMASK_NR52  8'h70

`define SPU_RST_NR21  8'h3F
`define SPU_RST_NR22  8'h00
`define SPU_RST_NR23  8'hFF
`define SPU_RST_NR24  8'hBF
`define SPU_RST_NR30  8'h7F
`define SPU_RST_NR31  8'hFF
`define SPU_RST_NR32  8'h9F
`define SPU_RST_NR33  8'hFF
`define SPU_RST_NR34  8'hBF
`define SPU_RST_NR50  8'h77
`define SPU_RST_NR51  8'hF3
`define SPU_RST_NR52  8'hF1

// field positions
`define SPU_TRIG_BIT    7
`define SPU_LEN_EN_BIT  6
`define SPU_POWER_BIT   7
`define SPU_DAC_MASK    8'hF8

`endif

// ==== hdl/spu_mixer.sv ====
module spu_mixer (
  input  spu_pkg::chan_sample_t pulse_out,
  input  spu_pkg::chan_sample_t wave_out,
  input  spu_pkg::spu_regs_t    regs,
  output spu_pkg::sample_t      out_l,
  output spu_pkg::sample_t      out_r
);
  import spu_pkg::*;

  sample_t    sum_l;
  sample_t    sum_r;
  logic [3:0] vol_l;
  logic [3:0] vol_r;

  // nr51 routing, ch2 on bits 1/5 and ch3 on bits 2/6
  assign sum_r = (regs.nr51[1] ? sample_t'(pulse_out) : sample_t'(0)) +
                 (regs.nr51[2] ? sample_t'(wave_out) : sample_t'(0));
  assign sum_l = (regs.nr51[5] ? sample_t'(pulse_out) : sample_t'(0)) +
                 (regs.nr51[6] ? sample_t'(wave_out) : sample_t'(0));

  // master volume 1..8
  assign vol_r = {1'b0, regs.nr50[2:0]} + 4'd1;
  assign vol_l = {1'b0, regs.nr50[6:4]} + 4'd1;

  assign out_r = sum_r * sample_t'(vol_r);
  assign out_l = sum_l * sample_t'(vol_l);

endmodule

// ==== hdl/spu_pkg.sv ====
`include "spu_consts.svh"

package spu_pkg;

  typedef logic [`SPU_ADDR_W-1:0]   spu_addr_t;
  typedef logic [`SPU_DATA_W-1:0]   spu_data_t;
  typedef logic [`SPU_SAMPLE_W-1:0] sample_t;
  typedef logic [7:0]               chan_sample_t;

  // ch2, ch3 and master control registers
  typedef struct packed {
    spu_data_t nr21;
    spu_data_t nr22;
    spu_data_t nr23;
    spu_data_t nr24;
    spu_data_t nr30;
    spu_data_t nr31;
    spu_data_t nr32;
    spu_data_t nr33;
    spu_data_t nr34;
    spu_data_t nr50;
    spu_data_t nr51;
    spu_data_t nr52;
  } spu_regs_t;

  typedef struct packed {
    logic pulse;
    logic wave;
  } spu_trig_t;

  typedef struct packed {
    logic pulse;
    logic wave;
  } spu_enables_t;

  typedef struct packed {
    logic [3:0] index;
    logic       write;
    logic       read;
    spu_data_t  data;
  } wave_bus_req_t;

  // the bus sees a byte, the wave channel sees two samples
  typedef union packed {
    spu_data_t raw;
    struct packed {
      logic [3:0] hi;
      logic [3:0] lo;
    } nib;
  } wave_byte_u;

endpackage

// ==== hdl/spu_reg_file.sv ====
`include "spu_consts.svh"

module spu_reg_file (
  input  logic                  clock,
  input  logic                  tick_reset,
  input  logic                  tick_we,
  input  spu_pkg::spu_addr_t    tick_addr,
  input  spu_pkg::spu_addr_t    tock_ack_addr,
  input  spu_pkg::spu_data_t    tick_data,
  input  spu_pkg::wave_byte_u   wave_rdata,
  input  spu_pkg::spu_enables_t enables,
  output spu_pkg::spu_regs_t    regs,
  output spu_pkg::spu_trig_t    trig,
  output spu_pkg::wave_bus_req_t wave_req,
  output spu_pkg::spu_data_t    ack_data,
  output logic                  ack_valid
);
  import spu_pkg::*;

  logic wave_wr;
  logic wave_rd;

  assign wave_wr = tick_we && (tick_addr >= `SPU_ADDR_WAVE_BASE) &&
                   (tick_addr <= `SPU_ADDR_WAVE_TOP);
  assign wave_rd = (tock_ack_addr >= `SPU_ADDR_WAVE_BASE) &&
                   (tock_ack_addr <= `SPU_ADDR_WAVE_TOP);

  // a write owns the index when both sides hit the window
  assign wave_req = '{
    index: wave_wr ? tick_addr[3:0] : tock_ack_addr[3:0],
    write: wave_wr,
    read:  wave_rd,
    data:  tick_data
  };

  // ---------------------------------------------------------------------------
  // register writes and triggers
  // ---------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (tick_reset) begin
      regs <= '{
        nr21: `SPU_RST_NR21, nr22: `SPU_RST_NR22, nr23: `SPU_RST_NR23,
        nr24: `SPU_RST_NR24, nr30: `SPU_RST_NR30, nr31: `SPU_RST_NR31,
        nr32: `SPU_RST_NR32, nr33: `SPU_RST_NR33, nr34: `SPU_RST_NR34,
        nr50: `SPU_RST_NR50, nr51: `SPU_RST_NR51, nr52: `SPU_RST_NR52
      };
      trig <= '0;
    end else begin
      trig.pulse <= tick_we && (tick_addr == `SPU_ADDR_NR24) && tick_data[`SPU_TRIG_BIT];
      trig.wave  <= tick_we && (tick_addr == `SPU_ADDR_NR34) && tick_data[`SPU_TRIG_BIT];
      if (tick_we) begin
        case (tick_addr)
          `SPU_ADDR_NR21: regs.nr21 <= tick_data;
          `SPU_ADDR_NR22: regs.nr22 <= tick_data;
          `SPU_ADDR_NR23: regs.nr23 <= tick_data;
          `SPU_ADDR_NR24: regs.nr24 <= tick_data | `SPU_WMASK_NR24;
          `SPU_ADDR_NR30: regs.nr30 <= tick_data | `SPU_WMASK_NR30;
          `SPU_ADDR_NR31: regs.nr31 <= tick_data;
          `SPU_ADDR_NR32: regs.nr32 <= tick_data | `SPU_WMASK_NR32;
          `SPU_ADDR_NR33: regs.nr33 <= tick_data;
          `SPU_ADDR_NR34: regs.nr34 <= tick_data | `SPU_WMASK_NR34;
          `SPU_ADDR_NR50: regs.nr50 <= tick_data;
          `SPU_ADDR_NR51: regs.nr51 <= tick_data;
          `SPU_ADDR_NR52: regs.nr52 <= tick_data | `SPU_WMASK_NR52;
          default: ;
        endcase
      end
    end
  end

  // ---------------------------------------------------------------------------
  // combinational readback
  // ---------------------------------------------------------------------------
  always_comb begin
    spu_data_t nr52_rd;
    // power bit, fixed ones, then live channel status
    nr52_rd = (regs.nr52 & 8'h80) | `SPU_RMASK_NR52 |
              {5'd0, enables.wave, enables.pulse, 1'b0};
    ack_data = '0;
    ack_valid = 1'b0;
    if (wave_rd) begin
      ack_data = wave_rdata.raw;
      ack_valid = 1'b1;
    end else if ((tock_ack_addr >= `SPU_ADDR_REG_BASE) &&
                 (tock_ack_addr <= `SPU_ADDR_NR52)) begin
      // dropped channels fall through to all ones
      ack_data = 8'hFF;
      ack_valid = 1'b1;
      case (tock_ack_addr)
        `SPU_ADDR_NR21: ack_data = regs.nr21 | `SPU_RMASK_NR21;
        `SPU_ADDR_NR22: ack_data = regs.nr22 | `SPU_RMASK_NR22;
        `SPU_ADDR_NR23: ack_data = regs.nr23 | `SPU_RMASK_NR23;
        `SPU_ADDR_NR24: ack_data = regs.nr24 | `SPU_RMASK_NR24;
        `SPU_ADDR_NR30: ack_data = regs.nr30 | `SPU_RMASK_NR30;
        `SPU_ADDR_NR31: ack_data = regs.nr31 | `SPU_RMASK_NR31;
        `SPU_ADDR_NR32: ack_data = regs.nr32 | `SPU_RMASK_NR32;
        `SPU_ADDR_NR33: ack_data = regs.nr33 | `SPU_RMASK_NR33;
        `SPU_ADDR_NR34: ack_data = regs.nr34 | `SPU_RMASK_NR34;
        `SPU_ADDR_NR50: ack_data = regs.nr50 | `SPU_RMASK_NR50;
        `SPU_ADDR_NR51: ack_data = regs.nr51 | `SPU_RMASK_NR51;
        `SPU_ADDR_NR52: ack_data = nr52_rd;
        default: ack_valid = 1'b0;
      endcase
    end
  end

  // a trigger pulse always comes from a bus write one edge earlier
  trig_after_write: assert property (@(posedge clock) disable iff (tick_reset)
    (trig.pulse || trig.wave) |-> $past(tick_we));

endmodule

// ==== hdl/wave_channel.sv ====
`include "spu_consts.svh"

module wave_channel (
  input  logic                  clock,
  input  logic                  tick_reset,
  input  spu_pkg::spu_regs_t    regs,
  input  spu_pkg::spu_trig_t    trig,
  input  spu_pkg::spu_enables_t enables,
  output logic                  fetch_req,
  output logic [3:0]            fetch_index,
  input  logic                  fetch_grant,
  input  spu_pkg::wave_byte_u   fetch_data,
  output spu_pkg::chan_sample_t wave_out
);
  import spu_pkg::*;

  logic [10:0]  period_cnt;
  logic [10:0]  reload;
  logic [4:0]   phase;
  logic [15:0]  stepped;
  logic [10:0]  cnt_d;
  logic [4:0]   phase_d;
  logic [4:0]   req_phase;
  logic [2:0]   shift;
  logic [3:0]   nibble;
  chan_sample_t shifted;

  // state is {phase, period count}
  function automatic logic [15:0] phase_step(input logic [15:0] st,
                                             input logic [10:0] rl);
    if (st[10:0] == 11'd0) begin
      phase_step = {st[15:11] + 5'd1, rl};
    end else begin
      phase_step = {st[15:11], st[10:0] - 11'd1};
    end
  endfunction

  assign reload  = 11'(`SPU_FREQ_MAX) ^ {regs.nr34[2:0], regs.nr33};
  // ch3 runs at twice the rate of ch2
  assign stepped = phase_step(phase_step({phase, period_cnt}, reload), reload);
  assign phase_d = trig.wave ? 5'd0 : stepped[15:11];
  assign cnt_d   = trig.wave ? reload : stepped[10:0];

  assign fetch_index = req_phase[4:1];
  assign nibble  = req_phase[0] ? fetch_data.nib.lo : fetch_data.nib.hi;
  assign shifted = chan_sample_t'(nibble) >> shift;

  always_comb begin
    case (regs.nr32[6:5])
      2'd0: shift = 3'd4;
      2'd1: shift = 3'd0;
      2'd2: shift = 3'd1;
      default: shift = 3'd2;
    endcase
  end

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      period_cnt <= '0;
      phase      <= '0;
      req_phase  <= '0;
      fetch_req  <= 1'b0;
      wave_out   <= '0;
    end else begin
      phase      <= phase_d;
      period_cnt <= cnt_d;
      // new request only once the last one went through
      if (!fetch_req || fetch_grant) begin
        fetch_req <= enables.wave;
        req_phase <= phase_d;
      end
      if (!(enables.wave && regs.nr30[`SPU_POWER_BIT])) begin
        wave_out <= '0;
      end else if (fetch_grant) begin
        wave_out <= shifted;
      end
    end
  end

endmodule

// ==== hdl/wave_ram_arbiter.sv ====
`include "spu_consts.svh"

module wave_ram_arbiter (
  input  logic                   clock,
  input  logic                   tick_reset,
  input  spu_pkg::wave_bus_req_t wave_req,
  output spu_pkg::wave_byte_u    wave_rdata,
  input  logic                   fetch_req,
  input  logic [3:0]             fetch_index,
  output logic                   fetch_grant,
  output spu_pkg::wave_byte_u    fetch_data
);
  import spu_pkg::*;

  spu_data_t  ram [`SPU_WAVE_DEPTH];
  logic       bus_busy;
  logic [3:0] port_index;
  spu_data_t  port_data;

  // bus has fixed priority, the channel waits
  assign bus_busy    = wave_req.read || wave_req.write;
  assign port_index  = bus_busy ? wave_req.index : fetch_index;
  assign port_data   = ram[port_index];
  assign fetch_grant = fetch_req && !bus_busy;

  // single read port shared by both sides
  assign wave_rdata.raw = port_data;
  assign fetch_data.raw = port_data;

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      for (int i = 0; i < `SPU_WAVE_DEPTH; i++) begin
        ram[i] <= '0;
      end
    end else if (wave_req.write) begin
      ram[wave_req.index] <= wave_req.data;
    end
  end

  no_grant_under_bus: assert property (@(posedge clock) disable iff (tick_reset)
    bus_busy |-> !fetch_grant);

  // a stalled fetch keeps its request and index until granted
  fetch_held: assert property (@(posedge clock) disable iff (tick_reset)
    (fetch_req && !fetch_grant) |=> (fetch_req && $stable(fetch_index)));

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/spu_pkg.sv
hdl/spu_reg_file.sv
hdl/wave_ram_arbiter.sv
hdl/length_unit.sv
hdl/pulse_channel.sv
hdl/wave_channel.sv
hdl/spu_mixer.sv
hdl/metro_spu.sv
verification/spu_tb.sv

// ==== verification/spu_tb.sv ====
`include "spu_consts.svh"

module spu_tb;
  import spu_pkg::*;

  logic      clock;
  logic      tick_reset;
  logic      tick_we;
  spu_addr_t tick_addr;
  spu_data_t tick_data;
  spu_addr_t tock_ack_addr;
  spu_data_t ack_data;
  logic      ack_valid;
  sample_t   out_l;
  sample_t   out_r;

  integer    seed;
  logic      rd_pending;
  spu_data_t exp_data;
  logic      exp_valid;

  metro_spu i_metro_spu (
    .clock(clock), .tick_reset(tick_reset), .tick_addr(tick_addr),
    .tick_data(tick_data), .tick_we(tick_we), .tock_ack_addr(tock_ack_addr),
    .ack_data(ack_data), .ack_valid(ack_valid), .out_l(out_l), .out_r(out_r)
  );

  always #5 clock = ~clock;

  // --------------------------------------------------------------------------
  // reference model of the register map and the mixer
  // --------------------------------------------------------------------------
  function automatic logic implemented(input spu_addr_t addr);
    implemented = ((addr >= `SPU_ADDR_NR21) && (addr <= `SPU_ADDR_NR34)) ||
                  ((addr >= `SPU_ADDR_NR50) && (addr <= `SPU_ADDR_NR52));
  endfunction

  function automatic spu_data_t read_mask(input spu_addr_t addr);
    case (addr)
      `SPU_ADDR_NR21: read_mask = `SPU_RMASK_NR21;
      `SPU_ADDR_NR22: read_mask = `SPU_RMASK_NR22;
      `SPU_ADDR_NR23: read_mask = `SPU_RMASK_NR23;
      `SPU_ADDR_NR24: read_mask = `SPU_RMASK_NR24;
      `SPU_ADDR_NR30: read_mask = `SPU_RMASK_NR30;
      `SPU_ADDR_NR31: read_mask = `SPU_RMASK_NR31;
      `SPU_ADDR_NR32: read_mask = `SPU_RMASK_NR32;
      `SPU_ADDR_NR33: read_mask = `SPU_RMASK_NR33;
      `SPU_ADDR_NR34: read_mask = `SPU_RMASK_NR34;
      default:        read_mask = 8'h00;
    endcase
  endfunction

  function automatic spu_data_t write_mask(input spu_addr_t addr);
    case (addr)
      `SPU_ADDR_NR24: write_mask = `SPU_WMASK_NR24;
      `SPU_ADDR_NR30: write_mask = `SPU_WMASK_NR30;
      `SPU_ADDR_NR32: write_mask = `SPU_WMASK_NR32;
      `SPU_ADDR_NR34: write_mask = `SPU_WMASK_NR34;
      default:        write_mask = 8'h00;
    endcase
  endfunction

  function automatic spu_data_t reset_value(input spu_addr_t addr);
    case (addr)
      `SPU_ADDR_NR21: reset_value = `SPU_RST_NR21;
      `SPU_ADDR_NR22: reset_value = `SPU_RST_NR22;
      `SPU_ADDR_NR23: reset_value = `SPU_RST_NR23;
      `SPU_ADDR_NR24: reset_value = `SPU_RST_NR24;
      `SPU_ADDR_NR30: reset_value = `SPU_RST_NR30;
      `SPU_ADDR_NR31: reset_value = `SPU_RST_NR31;
      `SPU_ADDR_NR32: reset_value = `SPU_RST_NR32;
      `SPU_ADDR_NR33: reset_value = `SPU_RST_NR33;
      `SPU_ADDR_NR34: reset_value = `SPU_RST_NR34;
      `SPU_ADDR_NR50: reset_value = `SPU_RST_NR50;
      default:        reset_value = `SPU_RST_NR51;
    endcase
  endfunction

  function automatic spu_data_t expected_readback(input spu_addr_t addr, input spu_data_t val);
    expected_readback = val | write_mask(addr) | read_mask(addr);
  endfunction

  // power bit, fixed ones, channel status in bits 1 and 2
  function automatic spu_data_t expected_nr52(input logic power, input logic pulse_on,
                                              input logic wave_on);
    expected_nr52 = {power, 3'b111, 1'b0, wave_on, pulse_on, 1'b0};
  endfunction

  function automatic sample_t expected_mix(input chan_sample_t pulse, input chan_sample_t wave,
                                           input spu_data_t route, input spu_data_t vol,
                                           input logic left);
    sample_t sum;
    int      gain;
    sum = 16'd0;
    if (left) begin
      if (route[5]) sum = sum + pulse;
      if (route[6]) sum = sum + wave;
      gain = int'(vol[6:4]) + 1;
    end else begin
      if (route[1]) sum = sum + pulse;
      if (route[2]) sum = sum + wave;
      gain = int'(vol[2:0]) + 1;
    end
    expected_mix = sample_t'(int'(sum) * gain);
  endfunction

  function automatic spu_data_t rand_byte();
    rand_byte = spu_data_t'($random(seed));
  endfunction

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input spu_data_t got, input spu_data_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // bus reads are compared mid-cycle
  always @(negedge clock) begin
    if (rd_pending) begin
      check_valid(ack_valid, exp_valid, $sformatf("ack_valid[%h]", tock_ack_addr));
      check_data(ack_data, exp_data, $sformatf("ack_data[%h]", tock_ack_addr));
    end
  end

  // --------------------------------------------------------------------------
  // bus tasks
  // --------------------------------------------------------------------------
  task automatic bus_write(input spu_addr_t addr, input spu_data_t data);
    @(posedge clock);
    tick_we   <= 1'b1;
    tick_addr <= addr;
    tick_data <= data;
    @(posedge clock);
    tick_we <= 1'b0;
  endtask

  // read in the cycle that starts at the current rising edge
  task automatic expect_read(input spu_addr_t addr, input spu_data_t data, input logic valid);
    tock_ack_addr <= addr;
    exp_data      <= data;
    exp_valid     <= valid;
    rd_pending    <= 1'b1;
    @(posedge clock);
    rd_pending <= 1'b0;
  endtask

  task automatic wait_status(input int pos, input logic value, input int limit);
    int cnt;
    cnt = 0;
    @(posedge clock);
    tock_ack_addr <= `SPU_ADDR_NR52;
    @(negedge clock);
    while ((ack_data[pos] !== value) && (cnt < limit)) begin
      @(negedge clock);
      cnt++;
    end
    if (ack_data[pos] !== value) begin
      report_failure($sformatf("timeout waiting for NR52 bit %0d to become %0b", pos, value));
    end
    @(posedge clock);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    spu_addr_t  addr;
    spu_data_t  d;
    spu_data_t  nr50;
    spu_data_t  wave_bytes [`SPU_WAVE_DEPTH];
    logic [3:0] n;
    logic [3:0] s;
    sample_t    exp_r;
    sample_t    hi;
    logic       seen_zero;
    logic       seen_hi;
    int         cnt;

    seed          = 8503;
    clock         = 1'b0;
    tick_reset    = 1'b1;
    tick_we       = 1'b0;
    tick_addr     = '0;
    tick_data     = '0;
    tock_ack_addr = '0;
    rd_pending    = 1'b0;
    exp_data      = '0;
    exp_valid     = 1'b0;
    repeat (3) @(posedge clock);
    tick_reset <= 1'b0;

    // reset values and all-ones reads of dropped channels
    for (int i = 0; i <= 22; i++) begin
      addr = `SPU_ADDR_REG_BASE + i;
      if (addr == `SPU_ADDR_NR52) begin
        expect_read(addr, expected_nr52(`SPU_RST_NR52 >> 7, 1'b0, 1'b0), 1'b1);
      end else if (implemented(addr)) begin
        expect_read(addr, expected_readback(addr, reset_value(addr)), 1'b1);
      end else begin
        expect_read(addr, 8'hFF, 1'b0);
      end
    end

    // random register writes with trigger bits kept clear
    for (int i = 0; i <= 22; i++) begin
      addr = `SPU_ADDR_REG_BASE + i;
      if (implemented(addr)) begin
        d = rand_byte();
        if ((addr == `SPU_ADDR_NR24) || (addr == `SPU_ADDR_NR34)) d[7] = 1'b0;
        bus_write(addr, d);
        if (addr == `SPU_ADDR_NR52) begin
          expect_read(addr, expected_nr52(d[7], 1'b0, 1'b0), 1'b1);
        end else begin
          expect_read(addr, expected_readback(addr, d), 1'b1);
        end
      end
    end

    // fill the whole wave RAM before reading it back
    for (int i = 0; i < `SPU_WAVE_DEPTH; i++) begin
      wave_bytes[i] = rand_byte();
      bus_write(`SPU_ADDR_WAVE_BASE + i, wave_bytes[i]);
    end
    for (int i = 0; i < `SPU_WAVE_DEPTH; i++) begin
      expect_read(`SPU_ADDR_WAVE_BASE + i, wave_bytes[i], 1'b1);
    end

    // status bits and length expiry at a length of one
    bus_write(`SPU_ADDR_NR52, 8'h80);
    bus_write(`SPU_ADDR_NR21, 8'h3F);
    bus_write(`SPU_ADDR_NR22, 8'hF0);
    bus_write(`SPU_ADDR_NR24, 8'hC0);
    wait_status(1, 1'b1, 8);
    expect_read(`SPU_ADDR_NR52, expected_nr52(1'b1, 1'b1, 1'b0), 1'b1);
    wait_status(1, 1'b0, 2 * 16384 + 64);
    bus_write(`SPU_ADDR_NR30, 8'h80);
    bus_write(`SPU_ADDR_NR31, 8'hFF);
    bus_write(`SPU_ADDR_NR32, 8'h20);
    bus_write(`SPU_ADDR_NR34, 8'hC0);
    wait_status(2, 1'b1, 8);
    expect_read(`SPU_ADDR_NR52, expected_nr52(1'b1, 1'b0, 1'b1), 1'b1);
    wait_status(2, 1'b0, 2 * 16384 + 64);

    // steady wave output on the right side
    d = rand_byte();
    n = (d[3:0] == 4'd0) ? 4'd7 : d[3:0];
    nr50 = rand_byte() & 8'h77;
    for (int i = 0; i < `SPU_WAVE_DEPTH; i++) begin
      bus_write(`SPU_ADDR_WAVE_BASE + i, {n, n});
    end
    bus_write(`SPU_ADDR_NR50, nr50);
    bus_write(`SPU_ADDR_NR51, 8'h04);
    bus_write(`SPU_ADDR_NR33, 8'h00);
    bus_write(`SPU_ADDR_NR34, 8'h87);
    exp_r = expected_mix(8'd0, {4'd0, n}, 8'h04, nr50, 1'b0);
    cnt = 0;
    @(negedge clock);
    while ((out_r !== exp_r) && (cnt < 200)) begin
      @(negedge clock);
      cnt++;
    end
    if (out_r !== exp_r) report_failure("timeout waiting for the wave output to settle");
    repeat (64) begin
      @(negedge clock);
      check_sample(out_r, exp_r, "out_r");
      check_sample(out_l, expected_mix(8'd0, {4'd0, n}, 8'h04, nr50, 1'b1), "out_l");
    end

    // both pulse levels must show up on the left
    d = rand_byte();
    s = (d[7:4] == 4'd0) ? 4'd5 : d[7:4];
    bus_write(`SPU_ADDR_NR21, 8'h80);
    bus_write(`SPU_ADDR_NR22, {s, 4'h0});
    bus_write(`SPU_ADDR_NR23, 8'hF0);
    bus_write(`SPU_ADDR_NR51, 8'h20);
    bus_write(`SPU_ADDR_NR24, 8'h87);
    hi = expected_mix({4'd0, s}, 8'd0, 8'h20, nr50, 1'b1);
    seen_zero = 1'b0;
    seen_hi   = 1'b0;
    cnt = 0;
    while (!(seen_zero && seen_hi) && (cnt < 1000)) begin
      @(negedge clock);
      if (out_l == 16'd0) begin
        seen_zero = 1'b1;
      end else begin
        check_sample(out_l, hi, "out_l");
        seen_hi = 1'b1;
      end
      cnt++;
    end
    if (!(seen_zero && seen_hi)) report_failure("timeout waiting for both pulse levels on out_l");

    repeat (4) @(posedge clock);
    $display("TEST PASS");
    $finish;
  end

endmodule
